// File: sources.f
+incdir+design
design/nf_bus_pkg.sv
design/nf_map_pkg.sv
design/nf_dm_if.sv
design/nf_router_dec.sv
design/nf_router_mux.sv
design/nf_router.sv
design/nf_dm_ram.sv
design/nf_dm_top.sv
test/nf_dm_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the data-memory testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module nf_dm_tb \
    -f sources.f \
    -o sim_nf_dm
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_nf_dm 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

// File: test/nf_dm_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nf_settings_params.svh"

module nf_dm_tb;

    localparam int clk_period        = 40;              // ns
    localparam int drive_delay       = 2;               // ns after the rising edge
    localparam int reset_cycles      = 16;
    localparam int directed_accesses = 120;             // tests 1 to 5, drain cycles included
    localparam int random_accesses   = 400;
    localparam int margin_cycles     = 60;
    localparam int timeout_cycles    = reset_cycles + directed_accesses + random_accesses
                                       + margin_cycles;
    localparam int total_words       = `slave_number * `ram_depth;
    localparam logic [31:0] map_bytes = `slave_number * `slave_window;   // first unmapped byte

    logic              clk;
    logic              rst_n;
    nf_bus_pkg::addr_t addr;
    logic              we;
    nf_bus_pkg::word_t wd;
    nf_bus_pkg::word_t rd;

    logic [31:0] model [total_words];                   // reference memory
    bit          model_ok [total_words];                // word written at least once
    int          offsets [4] = '{0, 1, 17, 1023};       // word offsets, both window ends

    logic        pend_chk = 1'b0;                       // read issued this cycle is checked
    logic [31:0] pend_exp = '0;
    logic [31:0] pend_addr = '0;
    logic        chk_q = 1'b0;                          // read sampled at the last edge
    logic [31:0] exp_q = '0;
    logic [31:0] addr_q = '0;
    logic        rst_chk = 1'b0;                        // rd must read zero

    integer seed = 32'h325e;
    int     errors = 0;
    int     errors_at_start = 0;
    int     checks = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;

    nf_dm_top nf_dm_top_i (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .addr  ( addr  ),
        .we    ( we    ),
        .wd    ( wd    ),
        .rd    ( rd    )
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // expectation follows the access into the dut by one edge
    always @(posedge clk) begin
        chk_q  <= pend_chk;
        exp_q  <= pend_exp;
        addr_q <= pend_addr;
        if (rst_chk) checks++;
        if (rst_n && chk_q) checks++;
    end

    a_reset_rd: assert property (@(posedge clk) rst_chk |-> (rd === '0))
        else begin
            $display("ERROR rd: got %h expected %h after reset", rd, 32'h0);
            errors++;
        end

    a_read_rd: assert property (@(posedge clk) disable iff (!rst_n) chk_q |-> (rd === exp_q))
        else begin
            $display("ERROR rd: got %h expected %h at addr %h", rd, exp_q, addr_q);
            errors++;
        end

    // byte address of word k in slave window i
    function automatic logic [31:0] word_addr(input int i, input int k);
        return i * `slave_window + k * 4;
    endfunction

    // one bus access, expected read data from the model
    task automatic access(input logic [31:0] a, input logic w, input logic [31:0] d);
        int unsigned widx;
        @(posedge clk);
        #drive_delay;
        addr      = a;
        we        = w;
        wd        = d;
        widx      = a >> 2;                             // low two bits ignored
        pend_addr = a;
        if (a >= map_bytes) begin
            pend_chk = !w;                              // unmapped write is dropped
            pend_exp = `unmapped_rdata;
        end else if (w) begin
            pend_chk       = 1'b0;
            model[widx]    = d;                         // done at the coming edge
            model_ok[widx] = 1'b1;
        end else begin
            pend_chk = model_ok[widx];                  // unwritten ram is unknown
            pend_exp = model[widx];
        end
    endtask

    // unchecked read of the last address
    task automatic idle_cycle();
        @(posedge clk);
        #drive_delay;
        we       = 1'b0;
        pend_chk = 1'b0;
    endtask

    task automatic end_test(input string name);
        idle_cycle();
        idle_cycle();                                   // last read checked by now
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin : main
        logic [31:0] a;
        logic [31:0] d;
        logic        w;
        int unsigned slot;
        addr  = '0;
        we    = 1'b0;
        wd    = '0;
        rst_n = 1'b0;
        for (int n = 0; n < total_words; n++) model_ok[n] = 1'b0;

        // test 1, rd quiet through reset and up to the first access
        repeat (2) @(posedge clk);
        #drive_delay;
        rst_chk = 1'b1;
        repeat (reset_cycles - 2) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        @(posedge clk);                                 // first access sampled here
        #drive_delay;
        rst_chk = 1'b0;
        end_test("reset");

        // test 2, write then read back, every slave
        for (int i = 0; i < `slave_number; i++)
            for (int k = 0; k < 4; k++)
                access(word_addr(i, offsets[k]), 1'b1, 32'hc0de_0000 | (i << 12) | offsets[k]);
        for (int i = 0; i < `slave_number; i++)
            for (int k = 0; k < 4; k++)
                access(word_addr(i, offsets[k]), 1'b0, '0);
        end_test("write_read");

        // test 3, same offset in every slave
        for (int i = 0; i < `slave_number; i++) access(word_addr(i, 5), 1'b1, 32'h1500_0000 | i);
        for (int i = 0; i < `slave_number; i++) begin
            access(word_addr(i, 5), 1'b1, 32'h2500_0000 | i);
            for (int j = 0; j < `slave_number; j++) access(word_addr(j, 5), 1'b0, '0);
        end
        end_test("isolation");

        // test 4, unmapped reads and dropped writes
        for (int k = 0; k < 4; k++) access(map_bytes + offsets[k] * 4, 1'b0, '0);
        access(32'hffff_fffc, 1'b0, '0);                // top of the address space
        for (int k = 0; k < 4; k++) access(map_bytes + offsets[k] * 4, 1'b1, 32'hbad0_0000 | k);
        for (int i = 0; i < `slave_number; i++)
            for (int k = 0; k < 4; k++)
                access(word_addr(i, offsets[k]), 1'b0, '0);   // aliased index untouched
        end_test("unmapped");

        // test 5, back-to-back reads, slave changes every cycle
        for (int j = 0; j < 8; j++)
            access(word_addr(j % `slave_number, offsets[(j + 1) % 4]), 1'b0, '0);
        for (int i = 0; i < `slave_number; i++) begin
            d = 32'h5a5a_0000 | (i << 8);
            access(word_addr(i, 9), 1'b1, d);
            access(word_addr(i, 9), 1'b0, '0);          // new data right away
        end
        end_test("pipelined");

        // test 6, seeded mix over the whole map
        repeat (random_accesses) begin
            slot = $unsigned($random(seed)) % (`slave_number + 1);
            if (slot == `slave_number) begin
                a = map_bytes + ($unsigned($random(seed)) & 32'h00ff_fffc);
            end else begin
                a = word_addr(slot, $unsigned($random(seed)) % 32)
                    | ($unsigned($random(seed)) & 32'h3);   // byte lanes ignored
            end
            w = ($unsigned($random(seed)) % 3) == 0;    // about one write in three
            d = $random(seed);
            access(a, w, d);
        end
        end_test("random");

        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && checks > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // run length bound by the access count
    initial begin : watchdog
        #(timeout_cycles * clk_period);
        $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule : nf_dm_tb

`default_nettype wire

// File: design/nf_dm_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "nf_settings_params.svh"

// data memory of the load/store path, router plus ram slaves
module nf_dm_top (
    input  logic              clk,             // clock
    input  logic              rst_n,           // async reset, active low
    input  nf_bus_pkg::addr_t addr,            // byte address from cpu
    input  logic              we,              // write enable
    input  nf_bus_pkg::word_t wd,              // write data
    output nf_bus_pkg::word_t rd               // read data, one cycle later
);

    nf_dm_if m_if ();                          // cpu to router
    nf_dm_if s_if [`slave_number] ();          // router to each ram

    assign m_if.addr = addr;
    assign m_if.we   = we;
    assign m_if.wd   = wd;
    assign rd        = m_if.rd;

    nf_router #(
        .slave_n ( `slave_number )
    ) nf_router_i (
        .clk     ( clk   ),
        .rst_n   ( rst_n ),
        .m       ( m_if  ),                    // master side
        .s       ( s_if  )                     // slave side array
    );

    genvar i;
    generate
        for (i = 0; i < `slave_number; i++) begin : g_ram
            nf_dm_ram #(
                .depth ( `ram_depth )          // one 4 KB window
            ) nf_dm_ram_i (
                .clk   ( clk     ),
                .bus   ( s_if[i] )
            );
        end
    endgenerate

endmodule : nf_dm_top

`default_nettype wire

// File: design/nf_dm_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "nf_settings_params.svh"

// one data-memory slave, word-wide ram with registered read
module nf_dm_ram #(
    parameter int depth = `ram_depth               // words in the window
) (
    input  logic    clk,                           // clock
    nf_dm_if.slave  bus                            // from the router
);

    nf_bus_pkg::word_t     mem [depth];            // ram array, contents not cleared
    nf_map_pkg::word_idx_t idx;                    // word offset in window
    logic                  we_known;               // we seen at a known level

    // byte address to word index, window base bits dropped
    assign idx = bus.addr[2 +: $bits(nf_map_pkg::word_idx_t)];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem[idx] <= bus.wd;                    // write at the edge
        end
        bus.rd <= mem[idx];                        // old data on read-during-write
    end

    // arms once the master leaves the unknown start-up state
    always_ff @(posedge clk) begin
        if (!$isunknown(bus.we)) begin
            we_known <= 1'b1;
        end
    end

    // after start-up, an x on we would corrupt an unknown word
    a_ram_we_known: assert property (@(posedge clk)
        (we_known === 1'b1) |-> !$isunknown(bus.we))
        else $error("nf_dm_ram: we unknown at addr %h", bus.addr);

    // index width must cover the array exactly
    initial begin
        a_ram_depth: assert (depth == (1 << $bits(nf_map_pkg::word_idx_t)))
            else $error("nf_dm_ram: depth %0d does not match word index", depth);
    end

endmodule : nf_dm_ram

`default_nettype wire

// File: design/nf_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "nf_settings_params.svh"

// routes lw/sw accesses from the cpu to one of the ram slaves
module nf_router #(
    parameter int slave_n = `slave_number          // ram slaves behind the router
) (
    input  logic       clk,                        // clock
    input  logic       rst_n,                      // async active-low reset
    nf_dm_if.slave     m,                          // cpu side
    nf_dm_if.master    s [slave_n]                 // one bus per ram slave
);

    nf_map_pkg::sel_t  slave_sel;                  // decoded window
    logic              unmapped;                   // no window hit
    logic [slave_n-1 : 0] we_s;                    // gated write enables
    nf_bus_pkg::word_t rd_s [slave_n];             // read data back from slaves

    nf_router_dec #(
        .slave_n   ( slave_n   )
    ) nf_router_dec_i (
        .addr      ( m.addr    ),                  // master address
        .slave_sel ( slave_sel ),                  // one-hot select
        .unmapped  ( unmapped  )                   // out of map
    );

    genvar i;
    generate
        for (i = 0; i < slave_n; i++) begin : g_fan
            assign s[i].addr = m.addr;                     // broadcast address
            assign s[i].wd   = m.wd;                       // broadcast write data
            assign we_s[i]   = m.we & slave_sel[i];        // write only the hit window
            assign s[i].we   = we_s[i];
            assign rd_s[i]   = s[i].rd;                    // collect for the mux
        end
    endgenerate

    nf_router_mux #(
        .slave_n   ( slave_n   )
    ) nf_router_mux_i (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .slave_sel ( slave_sel ),                  // registered inside
        .unmapped  ( unmapped  ),
        .rd_s      ( rd_s      ),
        .rd        ( m.rd      )                   // back to cpu
    );

    // at most one slave written per edge
    a_router_we: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(we_s))
        else $error("nf_router: we_s %b m.we %b addr %h", we_s, m.we, m.addr);

endmodule : nf_router

`default_nettype wire

// File: design/nf_router_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "nf_settings_params.svh"

// read-data return path, lines up with the one-cycle ram read
module nf_router_mux #(
    parameter int slave_n = `slave_number                  // ram slaves behind the router
) (
    input  logic              clk,                         // clock
    input  logic              rst_n,                       // async reset, active low
    input  nf_map_pkg::sel_t  slave_sel,                   // select for the current address
    input  logic              unmapped,                    // current address unmapped
    input  nf_bus_pkg::word_t rd_s [slave_n],              // registered read data per slave
    output nf_bus_pkg::word_t rd                           // read data to master
);

    nf_map_pkg::sel_t  sel_r;                              // select of the previous cycle
    logic              unmapped_r;                         // unmapped of the previous cycle
    nf_bus_pkg::word_t rd_or;                              // and-or of selected slave data

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_r      <= '0;                              // rd reads zero until first access
            unmapped_r <= 1'b0;
        end else begin
            sel_r      <= slave_sel;                       // every cycle is an access
            unmapped_r <= unmapped;
        end
    end

    always_comb begin
        rd_or = '0;
        for (int i = 0; i < slave_n; i++) begin
            if (sel_r[i]) begin
                rd_or = rd_or | rd_s[i];                   // only one term survives
            end
        end
    end

    assign rd = unmapped_r ? nf_bus_pkg::word_t'(`unmapped_rdata) : rd_or;   // fixed pattern

    // or-mux only works with at most one slave selected, and never with unmapped
    a_mux_sel: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(sel_r) && !(unmapped_r && (sel_r != '0)))
        else $error("nf_router_mux: sel_r %b unmapped_r %b", sel_r, unmapped_r);

endmodule : nf_router_mux

`default_nettype wire

// File: design/nf_router_dec.sv
`timescale 1ns/1ps
`default_nettype none

`include "nf_settings_params.svh"

// address decoder, one-hot slave select from the byte address
module nf_router_dec #(
    parameter int slave_n = `slave_number              // ram slaves behind the router
) (
    input  nf_bus_pkg::addr_t addr,                    // master byte address
    output nf_map_pkg::sel_t  slave_sel,               // one-hot window hit
    output logic              unmapped                 // above the last window
);

    nf_bus_pkg::addr_t offset;                         // address relative to window base

    always_comb begin
        slave_sel = '0;
        offset    = '0;
        for (int i = 0; i < slave_n; i++) begin
            offset       = addr - nf_map_pkg::slave_base(i);              // wraps when below base
            slave_sel[i] = offset < nf_bus_pkg::addr_t'(`slave_window);   // inside window i
        end
        // end of map checked on its own, not from the select
        unmapped = addr >= nf_map_pkg::slave_base(slave_n);

        // windows must not overlap, and the two views of the map must agree
        if (!$isunknown(addr)) begin
            a_dec_map: assert ($onehot0(slave_sel) && (unmapped == (slave_sel == '0)))
                else $error("nf_router_dec: addr %h sel %b unmapped %b",
                            addr, slave_sel, unmapped);
        end
    end

endmodule : nf_router_dec

`default_nettype wire

// File: design/nf_dm_if.sv
`timescale 1ns/1ps
`default_nettype none

// single-master data-memory bus, one access per clock, no back-pressure
interface nf_dm_if;

    nf_bus_pkg::addr_t addr;        // byte address
    logic              we;          // write enable, read when low
    nf_bus_pkg::word_t wd;          // write data
    nf_bus_pkg::word_t rd;          // read data, one cycle after addr

    // cpu or router side
    modport master (
        output addr,
        output we,
        output wd,
        input  rd
    );

    // router or ram side
    modport slave (
        input  addr,
        input  we,
        input  wd,
        output rd
    );

endinterface : nf_dm_if

`default_nettype wire

// File: design/nf_map_pkg.sv
`default_nettype none

`include "nf_settings_params.svh"

// address map of the ram slaves behind the router
package nf_map_pkg;

    // one bit per slave, at most one set
    typedef logic [`slave_number-1 : 0] sel_t;                 // one-hot slave select

    // word offset inside one 4 KB window
    typedef logic [$clog2(`ram_depth)-1 : 0] word_idx_t;       // addr bits above bit 1

    // first byte of slave window idx
    function automatic nf_bus_pkg::addr_t slave_base(input int unsigned idx);
        nf_bus_pkg::addr_t base;                              // byte address of window start
        base = nf_bus_pkg::addr_t'(idx * `slave_window);      // windows packed from zero up
        return base;
    endfunction : slave_base

endpackage : nf_map_pkg

`default_nettype wire

// File: design/nf_bus_pkg.sv
`default_nettype none

// data types seen on both ends of the data-memory bus
package nf_bus_pkg;

    // one data word, as written by sw and returned to lw
    typedef logic [31 : 0] word_t;             // 32-bit data word

    // byte address from the cpu
    typedef logic [31 : 0] addr_t;             // low two bits ignored, word access only

endpackage : nf_bus_pkg

`default_nettype wire

// File: design/nf_settings_params.svh
`ifndef NF_SETTINGS_PARAMS_SVH
`define NF_SETTINGS_PARAMS_SVH

// data-memory address map of the load/store path

// number of ram slaves hanging off the router
`define slave_number    4

// bytes per slave window, 4 KB
`define slave_window    4096

// words per slave
`define ram_depth       (`slave_window / 4)

// what a read returns above the last window
`define unmapped_rdata  32'hdead_beef

`endif
